// ==== cpu_pkg.sv ====
package cpu_pkg;

  // number of architectural registers
  localparam int reg_count = 16;

  // width of the sign-extended immediate field
  localparam int imm_width = 20;

  // register index
  typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

  // opcodes, top nibble of the word
  typedef enum logic [3:0] {
    op_add  = 4'h0,
    op_sub  = 4'h1,
    op_and  = 4'h2,
    op_or   = 4'h3,
    op_xor  = 4'h4,
    op_addi = 4'h5,
    op_lw   = 4'h6,
    op_sw   = 4'h7
  } op_e;

  // register format: rd = rs op rt
  typedef struct packed {
    op_e         op;
    reg_addr_t   rd;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [15:0] unused;
  } r_fmt_t;

  // immediate format: addi, lw, sw
  // for sw the rd field names the store source
  typedef struct packed {
    op_e                  op;
    reg_addr_t            rd;
    reg_addr_t            rs;
    logic [imm_width-1:0] imm;
  } i_fmt_t;

  // one 32-bit word, two views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

endpackage

// ==== exec_if.sv ====
`timescale 1ns/1ps

interface exec_if #(
  parameter int data_width = 32
);
  import cpu_pkg::*;

  // one-cycle start strobe for the execute stage
  logic                  exec_en;
  op_e                   op;
  // destination, or base register for sw
  reg_addr_t             rd;
  logic [data_width-1:0] rs_val;
  logic [data_width-1:0] rt_val;
  // already sign-extended
  logic [data_width-1:0] imm;

  modport decode (
    output exec_en,
    output op,
    output rd,
    output rs_val,
    output rt_val,
    output imm
  );

  modport execute (
    input exec_en,
    input op,
    input rd,
    input rs_val,
    input rt_val,
    input imm
  );

endinterface

// ==== mem_if.sv ====
`timescale 1ns/1ps

interface mem_if #(
  parameter int data_width = 32,
  parameter int mem_depth  = 4096
);
  import cpu_pkg::*;

  localparam int addr_width = $clog2(mem_depth);

  // memory strobes, same meaning as the data memory block
  logic                  enable_mem;
  logic                  enable_fetch;
  logic                  enable_writeback;
  // marks the cycle an instruction sits in the memory stage
  logic                  exec_valid;
  logic [addr_width-1:0] address;
  logic [data_width-1:0] wdata;
  logic [data_width-1:0] rdata;
  logic [data_width-1:0] alu_result;
  reg_addr_t             rd_out;

  modport exec (
    output enable_mem,
    output enable_fetch,
    output enable_writeback,
    output exec_valid,
    output address,
    output wdata,
    output alu_result,
    output rd_out
  );

  modport mem (
    input  enable_mem,
    input  enable_fetch,
    input  enable_writeback,
    input  address,
    input  wdata,
    output rdata
  );

  modport result (
    input enable_mem,
    input enable_fetch,
    input enable_writeback,
    input exec_valid,
    input wdata,
    input rdata,
    input alu_result,
    input rd_out
  );

endinterface

// ==== instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode #(
  parameter int data_width = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  instr_valid,
  input  cpu_pkg::instr_u       instr,
  output logic                  busy,
  output cpu_pkg::reg_addr_t    rd_addr_a,
  output cpu_pkg::reg_addr_t    rd_addr_b,
  input  logic [data_width-1:0] rd_data_a,
  input  logic [data_width-1:0] rd_data_b,
  exec_if.decode                ex
);
  import cpu_pkg::*;

  // sequencer states
  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_operand = 2'd1;
  localparam logic [1:0] st_execute = 2'd2;
  localparam logic [1:0] st_drain   = 2'd3;

  logic [1:0]            state;
  // two drain cycles: memory, then writeback
  logic                  drain_cnt;
  instr_u                ir;
  op_e                   op;
  logic                  imm_form;
  logic [data_width-1:0] imm_ext;

  assign busy = (state != st_idle);

  // field decode off the latched word
  assign op       = ir.r.op;
  assign imm_form = (op == op_addi) || (op == op_lw) || (op == op_sw);
  assign imm_ext  = {{(data_width-imm_width){ir.i.imm[imm_width-1]}}, ir.i.imm};

  // port a: rs, same bits in both formats
  assign rd_addr_a = ir.r.rs;
  // port b: rt, or the store source for sw
  assign rd_addr_b = (op == op_sw) ? ir.i.rd : ir.r.rt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      drain_cnt  <= 1'b0;
      ex.exec_en <= 1'b0;
    end else begin
      ex.exec_en <= 1'b0;
      case (state)
        st_idle: begin
          if (instr_valid) begin
            state <= st_operand;
          end
        end
        st_operand: begin
          state      <= st_execute;
          ex.exec_en <= 1'b1;
        end
        st_execute: begin
          state     <= st_drain;
          drain_cnt <= 1'b1;
        end
        default: begin
          // leave on the writeback edge
          if (drain_cnt) begin
            drain_cnt <= 1'b0;
          end else begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // word latch, only taken while idle
  always_ff @(posedge clk) begin
    if ((state == st_idle) && instr_valid) begin
      ir <= instr;
    end
  end

  // operand capture, reg file reads are combinational
  always_ff @(posedge clk) begin
    if (state == st_operand) begin
      ex.op     <= op;
      // sw reports its base register
      ex.rd     <= (op == op_sw) ? ir.i.rs : ir.r.rd;
      ex.rs_val <= rd_data_a;
      ex.rt_val <= rd_data_b;
      ex.imm    <= imm_form ? imm_ext : '0;
    end
  end

  // execute never fires while the sequencer is idle
  a_exec_not_idle: assert property (
    @(posedge clk) disable iff (rst) ex.exec_en |-> state != st_idle
  );

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
  parameter int data_width = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  cpu_pkg::reg_addr_t    rd_addr_a,
  input  cpu_pkg::reg_addr_t    rd_addr_b,
  output logic [data_width-1:0] rd_data_a,
  output logic [data_width-1:0] rd_data_b,
  input  logic                  we,
  input  cpu_pkg::reg_addr_t    waddr,
  input  logic [data_width-1:0] wdata
);
  import cpu_pkg::*;

  logic [data_width-1:0] regs [reg_count];

  // r0 is hardwired to zero on both read ports
  assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

  always_ff @(posedge clk) begin
    if (rst) begin
      // whole file cleared
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // writeback filters rd 0 upstream
  a_no_r0_write: assert property (
    @(posedge clk) disable iff (rst) we |-> waddr != '0
  );

endmodule

// ==== alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute #(
  parameter int data_width = 32,
  parameter int mem_depth  = 4096
) (
  input  logic      clk,
  input  logic      rst,
  exec_if.execute   ex,
  mem_if.exec       m
);
  import cpu_pkg::*;

  localparam int addr_width = $clog2(mem_depth);

  logic [data_width-1:0] sum_imm;
  logic [data_width-1:0] alu_next;
  logic                  is_lw;
  logic                  is_sw;

  assign is_lw = (ex.op == op_lw);
  assign is_sw = (ex.op == op_sw);

  // rs + imm serves addi and the effective address
  assign sum_imm = ex.rs_val + ex.imm;

  always_comb begin
    case (ex.op)
      op_add:  alu_next = ex.rs_val + ex.rt_val;
      op_sub:  alu_next = ex.rs_val - ex.rt_val;
      op_and:  alu_next = ex.rs_val & ex.rt_val;
      op_or:   alu_next = ex.rs_val | ex.rt_val;
      op_xor:  alu_next = ex.rs_val ^ ex.rt_val;
      // addi, lw, sw
      default: alu_next = sum_imm;
    endcase
  end

  // results hold until the next exec_en
  always_ff @(posedge clk) begin
    if (ex.exec_en) begin
      m.alu_result <= alu_next;
      // address wraps at mem_depth
      m.address    <= sum_imm[addr_width-1:0];
      m.wdata      <= ex.rt_val;
      m.rd_out     <= ex.rd;
    end
  end

  // strobes live for one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      m.exec_valid       <= 1'b0;
      m.enable_mem       <= 1'b0;
      m.enable_fetch     <= 1'b0;
      m.enable_writeback <= 1'b0;
    end else begin
      m.exec_valid       <= ex.exec_en;
      m.enable_mem       <= ex.exec_en && (is_lw || is_sw);
      m.enable_fetch     <= ex.exec_en && is_lw;
      m.enable_writeback <= ex.exec_en && is_sw;
    end
  end

  // a single op never both loads and stores
  a_fetch_xor_wb: assert property (
    @(posedge clk) disable iff (rst) !(m.enable_fetch && m.enable_writeback)
  );

endmodule

// ==== data_mem.sv ====
`timescale 1ns/1ps

module data_mem #(
  parameter int data_width = 32,
  parameter int mem_depth  = 4096
) (
  input  logic clk,
  input  logic rst,
  mem_if.mem   m
);

  logic [data_width-1:0] mem_data [mem_depth];

  // one port, either a fetch or a writeback per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      // every word and the read register come up zero
      for (int i = 0; i < mem_depth; i++) begin
        mem_data[i] <= '0;
      end
      m.rdata <= '0;
    end else if (m.enable_mem) begin
      // fetch takes priority
      if (m.enable_fetch) begin
        m.rdata <= mem_data[m.address];
      end else if (m.enable_writeback) begin
        mem_data[m.address] <= m.wdata;
      end
    end
  end

  // execute truncates the address, never out of range
  a_addr_range: assert property (
    @(posedge clk) disable iff (rst) m.enable_mem |-> m.address < mem_depth
  );

endmodule

// ==== result_writeback.sv ====
`timescale 1ns/1ps

module result_writeback #(
  parameter int data_width = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  mem_if.result                 m,
  output logic                  we,
  output cpu_pkg::reg_addr_t    waddr,
  output logic [data_width-1:0] wdata,
  output logic                  result_valid,
  output cpu_pkg::reg_addr_t    result_rd,
  output logic [data_width-1:0] result
);

  // instruction sitting in writeback this cycle
  logic                  pending;
  logic                  was_lw;
  logic                  was_sw;
  logic [data_width-1:0] sel_data;

  // follow the memory stage one edge behind
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      was_lw  <= 1'b0;
      was_sw  <= 1'b0;
    end else begin
      pending <= m.exec_valid;
      was_lw  <= m.enable_mem && m.enable_fetch;
      was_sw  <= m.enable_mem && m.enable_writeback && !m.enable_fetch;
    end
  end

  // loaded word, stored word, or alu result
  assign sel_data = was_lw ? m.rdata : (was_sw ? m.wdata : m.alu_result);

  // sw and rd 0 leave the file alone
  assign we    = pending && !was_sw && (m.rd_out != '0);
  assign waddr = m.rd_out;
  assign wdata = sel_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= pending;
    end
  end

  // reported alongside the pulse
  always_ff @(posedge clk) begin
    if (pending) begin
      result_rd <= m.rd_out;
      result    <= sel_data;
    end
  end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
  parameter int data_width = 32,
  parameter int mem_depth  = 4096
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  instr_valid,
  input  logic [31:0]           instr,
  output logic                  busy,
  output logic                  result_valid,
  output cpu_pkg::reg_addr_t    result_rd,
  output logic [data_width-1:0] result
);
  import cpu_pkg::*;

  // register file read side
  reg_addr_t             rd_addr_a;
  reg_addr_t             rd_addr_b;
  logic [data_width-1:0] rd_data_a;
  logic [data_width-1:0] rd_data_b;

  // register file write side
  logic                  rf_we;
  reg_addr_t             rf_waddr;
  logic [data_width-1:0] rf_wdata;

  exec_if #(.data_width(data_width)) ex_bus ();

  mem_if #(
    .data_width(data_width),
    .mem_depth (mem_depth)
  ) mem_bus ();

  instr_decode #(.data_width(data_width)) u_decode (
    .clk        (clk),
    .rst        (rst),
    .instr_valid(instr_valid),
    .instr      (instr),
    .busy       (busy),
    .rd_addr_a  (rd_addr_a),
    .rd_addr_b  (rd_addr_b),
    .rd_data_a  (rd_data_a),
    .rd_data_b  (rd_data_b),
    .ex         (ex_bus)
  );

  reg_file #(.data_width(data_width)) u_regs (
    .clk      (clk),
    .rst      (rst),
    .rd_addr_a(rd_addr_a),
    .rd_addr_b(rd_addr_b),
    .rd_data_a(rd_data_a),
    .rd_data_b(rd_data_b),
    .we       (rf_we),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

  alu_execute #(
    .data_width(data_width),
    .mem_depth (mem_depth)
  ) u_execute (
    .clk(clk),
    .rst(rst),
    .ex (ex_bus),
    .m  (mem_bus)
  );

  data_mem #(
    .data_width(data_width),
    .mem_depth (mem_depth)
  ) u_dmem (
    .clk(clk),
    .rst(rst),
    .m  (mem_bus)
  );

  result_writeback #(.data_width(data_width)) u_writeback (
    .clk         (clk),
    .rst         (rst),
    .m           (mem_bus),
    .we          (rf_we),
    .waddr       (rf_waddr),
    .wdata       (rf_wdata),
    .result_valid(result_valid),
    .result_rd   (result_rd),
    .result      (result)
  );

endmodule

// ==== tb_cpu_top.sv ====
`timescale 1ns/1ps

module tb_cpu_top;
  import cpu_pkg::*;

  localparam int data_width   = 32;
  localparam int mem_depth    = 4096;
  // instructions issued below, rounded up
  localparam int instr_budget = 48;
  // six cycles per instruction, reset, some slack
  localparam int cycle_limit  = instr_budget * 6 + 8 + 40;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  instr_valid;
  logic [31:0]           instr;
  logic                  busy;
  logic                  result_valid;
  reg_addr_t             result_rd;
  logic [data_width-1:0] result;

  // reference model state
  logic [31:0] model_regs [reg_count];
  logic [31:0] model_mem [mem_depth];
  // expectation of the instruction about to be issued
  logic [31:0] pend_result;
  reg_addr_t   pend_rd;
  // expectation of the instruction in flight
  logic [31:0] exp_result;
  reg_addr_t   exp_rd;

  logic [31:0] lcg_state;
  // pulse instr_valid once while the next instruction is busy
  bit          busy_poke;
  int          value_errors;
  int          timing_errors;
  int          cycles;
  logic        accept;

  always #2 clk = ~clk;

  cpu_top UUT (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .busy        (busy),
    .result_valid(result_valid),
    .result_rd   (result_rd),
    .result      (result)
  );

  assign accept = instr_valid && !busy;

  // hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // expectation moves to the in-flight slot on the accepting edge
  always @(posedge clk) begin
    if (!rst && accept) begin
      exp_result <= pend_result;
      exp_rd     <= pend_rd;
    end
  end

  a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !busy && !result_valid)
    else begin
      timing_errors++;
      $display("at %0t: busy or result_valid high right after reset", $time);
    end

  // pulse is set on the fourth edge, seen at the fifth sample
  a_latency: assert property (@(posedge clk) disable iff (rst) accept |-> ##5 result_valid)
    else begin
      timing_errors++;
      $display("at %0t: no result_valid four cycles after acceptance", $time);
    end

  a_no_extra: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> $past(accept, 5))
    else begin
      timing_errors++;
      $display("at %0t: result_valid without a matching accepted instruction", $time);
    end

  a_busy_span: assert property (@(posedge clk) disable iff (rst)
    accept |=> busy [*4] ##1 !busy)
    else begin
      timing_errors++;
      $display("at %0t: busy not held from acceptance to result_valid", $time);
    end

  a_result: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> result == exp_result)
    else begin
      value_errors++;
      $display("FAILED time=%0t signal=result expected=%h actual=%h",
               $time, $sampled(exp_result), $sampled(result));
    end

  a_result_rd: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> result_rd == exp_rd)
    else begin
      value_errors++;
      $display("FAILED time=%0t signal=result_rd expected=%0d actual=%0d",
               $time, $sampled(exp_rd), $sampled(result_rd));
    end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // 1..15, upper bits are the better ones
  function automatic reg_addr_t pick_reg();
    logic [31:0] r;
    r = next_rand();
    return reg_addr_t'(r[31:16] % 15 + 1);
  endfunction

  function automatic logic [31:0] reg_value(input reg_addr_t idx);
    return (idx == 0) ? 32'h0 : model_regs[idx];
  endfunction

  function automatic logic [31:0] r_word(input op_e op, input reg_addr_t rd,
                                         input reg_addr_t rs, input reg_addr_t rt);
    return {op, rd, rs, rt, 16'h0};
  endfunction

  function automatic logic [31:0] i_word(input op_e op, input reg_addr_t rd,
                                         input reg_addr_t rs, input logic [19:0] imm);
    return {op, rd, rs, imm};
  endfunction

  // called 1 ns after an edge, returns 1 ns after the result edge
  task automatic send_word(input logic [31:0] word);
    int n;
    instr_valid = 1'b1;
    instr       = word;
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    n = 0;
    while (!result_valid) begin
      // lands on the execute edge, must be ignored
      if (busy_poke && n == 1) begin
        instr_valid = 1'b1;
        instr       = next_rand();
      end else begin
        instr_valid = 1'b0;
      end
      @(posedge clk);
      #1;
      n++;
    end
    instr_valid = 1'b0;
    busy_poke   = 1'b0;
  endtask

  task automatic reg_op(input op_e op, input reg_addr_t rd,
                        input reg_addr_t rs, input reg_addr_t rt);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    a = reg_value(rs);
    b = reg_value(rt);
    case (op)
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_and:  res = a & b;
      op_or:   res = a | b;
      default: res = a ^ b;
    endcase
    if (rd != 0) begin
      model_regs[rd] = res;
    end
    pend_result = res;
    pend_rd     = rd;
    send_word(r_word(op, rd, rs, rt));
  endtask

  task automatic imm_op(input op_e op, input reg_addr_t rd,
                        input reg_addr_t rs, input logic [19:0] imm);
    logic [31:0] sum;
    logic [31:0] res;
    int          addr;
    sum  = reg_value(rs) + {{12{imm[19]}}, imm};
    // word address wraps at the memory size
    addr = sum % mem_depth;
    res  = sum;
    pend_rd = rd;
    case (op)
      op_lw: res = model_mem[addr];
      op_sw: begin
        // sw reports the stored word against its base register
        res = reg_value(rd);
        model_mem[addr] = res;
        pend_rd = rs;
      end
      default: res = sum;
    endcase
    if (op != op_sw && rd != 0) begin
      model_regs[rd] = res;
    end
    pend_result = res;
    send_word(i_word(op, rd, rs, imm));
  endtask

  initial begin
    logic [31:0] r;
    logic [19:0] slot;
    reg_addr_t   chain_rd;
    reg_addr_t   next_rd;
    lcg_state   = 32'd17969;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    busy_poke   = 1'b0;
    pend_result = '0;
    pend_rd     = '0;
    for (int i = 0; i < reg_count; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < mem_depth; i++) begin
      model_mem[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    // untouched memory reads zero
    repeat (3) begin
      r = next_rand();
      imm_op(op_lw, pick_reg(), 4'd0, r[19:0]);
    end

    // seed r1..r8, random imm covers negative values
    for (int i = 1; i <= 8; i++) begin
      r = next_rand();
      imm_op(op_addi, reg_addr_t'(i), 4'd0, r[19:0]);
    end

    repeat (2) begin
      reg_op(op_add, pick_reg(), pick_reg(), pick_reg());
      reg_op(op_sub, pick_reg(), pick_reg(), pick_reg());
      reg_op(op_and, pick_reg(), pick_reg(), pick_reg());
      reg_op(op_or,  pick_reg(), pick_reg(), pick_reg());
      reg_op(op_xor, pick_reg(), pick_reg(), pick_reg());
    end

    // all ones plus all ones wraps
    imm_op(op_addi, 4'd11, 4'd0, 20'hfffff);
    reg_op(op_add, 4'd12, 4'd11, 4'd11);

    // store, disturb the neighbours, load back
    r    = next_rand();
    slot = {8'h0, r[11:0] | 12'h001};
    imm_op(op_sw, 4'd3, 4'd0, slot);
    imm_op(op_sw, 4'd4, 4'd0, slot + 20'd1);
    imm_op(op_sw, 4'd5, 4'd0, slot - 20'd1);
    imm_op(op_lw, 4'd9, 4'd0, slot);

    // base near the top, address wraps to 2
    imm_op(op_addi, 4'd13, 4'd0, 20'd4095);
    imm_op(op_sw, 4'd6, 4'd13, 20'd3);
    imm_op(op_lw, 4'd14, 4'd0, 20'd2);

    // r0 stays zero after writes
    imm_op(op_addi, 4'd0, 4'd0, 20'd5);
    reg_op(op_add, 4'd15, 4'd0, 4'd0);
    reg_op(op_or, 4'd0, 4'd1, 4'd2);
    reg_op(op_xor, 4'd15, 4'd0, 4'd1);

    // stray instr_valid while busy
    busy_poke = 1'b1;
    reg_op(op_add, 4'd10, 4'd1, 4'd2);
    busy_poke = 1'b1;
    imm_op(op_lw, 4'd7, 4'd0, 20'd2);

    // dependent chain, each one reads the register the last one wrote
    chain_rd = 4'd7;
    repeat (8) begin
      r       = next_rand();
      next_rd = pick_reg();
      reg_op(op_e'(r[31:16] % 5), next_rd, chain_rd, pick_reg());
      chain_rd = next_rd;
    end

    repeat (3) @(posedge clk);
    #1;
    $display("result errors: %0d, timing errors: %0d", value_errors, timing_errors);
    if (value_errors == 0 && timing_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
cpu_pkg.sv
exec_if.sv
mem_if.sv
instr_decode.sv
reg_file.sv
alu_execute.sv
data_mem.sv
result_writeback.sv
cpu_top.sv
tb_cpu_top.sv

// ==== Bender.yml ====
package:
  name: cpu_top

sources:
  - cpu_pkg.sv
  - exec_if.sv
  - mem_if.sv
  - instr_decode.sv
  - reg_file.sv
  - alu_execute.sv
  - data_mem.sv
  - result_writeback.sv
  - cpu_top.sv
  - target: test
    files:
      - tb_cpu_top.sv
